// File: rtl/bju_settings.svh
`ifndef BJU_SETTINGS_SVH
`define BJU_SETTINGS_SVH

// execution side word widths
`define BJU_SRC_WIDTH     64
`define BJU_PC_WIDTH      48
`define BJU_RESULT_WIDTH  64

// one-hot branch kind: jal, jalr, beq, bne, blt, bge
`define BJU_CX_WIDTH      6

// predictor geometry
`define BHT_INDEX_WIDTH   9   // set index from pc[12:4]
`define BTB_SLOT_WIDTH    32
`define BTB_SLOTS         4   // slot picked by pc[3:2]

`endif

// File: rtl/bju_types_pkg.sv
`include "bju_settings.svh"

package bju_types_pkg;

    // operand, pc and link result words
    typedef logic [`BJU_SRC_WIDTH-1:0]    src_t;
    typedef logic [`BJU_PC_WIDTH-1:0]     pc_t;
    typedef logic [`BJU_RESULT_WIDTH-1:0] result_t;

    // bit positions inside the one-hot cx_type word
    // blt/bge double as bltu/bgeu when is_unsigned is set
    typedef enum int unsigned {
        CX_JAL  = 0,
        CX_JALR = 1,
        CX_BEQ  = 2,
        CX_BNE  = 3,
        CX_BLT  = 4,
        CX_BGE  = 5
    } cx_bit_e;

endpackage

// File: rtl/bpu_types_pkg.sv
`include "bju_settings.svh"

package bpu_types_pkg;

    // 2-bit saturating direction counter
    typedef logic [1:0] bht_ctr_t;

    localparam bht_ctr_t BHT_CTR_INIT = 2'b01;  // weakly not taken

    // structured view of one btb line, valid on top and slot 0 lowest
    typedef struct packed {
        logic                                       valid;
        logic [`BTB_SLOTS-1:0][`BTB_SLOT_WIDTH-1:0] slots;
    } btb_fields_t;

    // one btb line, also handled as a flat word for storage and masking
    typedef union packed {
        logic [`BTB_SLOTS*`BTB_SLOT_WIDTH:0] bits;
        btb_fields_t                         fields;
    } btb_line_u;

endpackage

// File: rtl/bju_issue_stage.sv
`timescale 1ns/1ps
`include "bju_settings.svh"

module bju_issue_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     valid,
    input  bju_types_pkg::src_t      src1,
    input  bju_types_pkg::src_t      src2,
    input  bju_types_pkg::src_t      imm,
    input  bju_types_pkg::pc_t       pc,
    input  logic [`BJU_CX_WIDTH-1:0] cx_type,
    input  logic                     is_unsigned,
    input  logic                     predict_taken,
    output logic                     iss_valid,
    output bju_types_pkg::src_t      iss_src1,
    output bju_types_pkg::src_t      iss_src2,
    output bju_types_pkg::src_t      iss_imm,
    output bju_types_pkg::pc_t       iss_pc,
    output logic [`BJU_CX_WIDTH-1:0] iss_cx_type,
    output logic                     iss_is_unsigned,
    output logic                     iss_predict_taken
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= valid;  // one branch per cycle, no stall
        end
    end

    // payload only moves when a branch is issued
    always_ff @(posedge clk) begin
        if (valid) begin
            iss_src1          <= src1;
            iss_src2          <= src2;
            iss_imm           <= imm;
            iss_pc            <= pc;
            iss_cx_type       <= cx_type;
            iss_is_unsigned   <= is_unsigned;
            iss_predict_taken <= predict_taken;
        end
    end

endmodule

// File: rtl/bju_resolve.sv
`timescale 1ns/1ps
`include "bju_settings.svh"

module bju_resolve (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         iss_valid,
    input  bju_types_pkg::src_t          iss_src1,
    input  bju_types_pkg::src_t          iss_src2,
    input  bju_types_pkg::src_t          iss_imm,
    input  bju_types_pkg::pc_t           iss_pc,
    input  logic [`BJU_CX_WIDTH-1:0]     iss_cx_type,
    input  logic                         iss_is_unsigned,
    input  logic                         iss_predict_taken,
    output bju_types_pkg::result_t       dest,
    output logic                         redirect_valid,
    output bju_types_pkg::pc_t           redirect_target,
    output logic                         bht_we,
    output logic [`BHT_INDEX_WIDTH-1:0]  bht_index,
    output logic [1:0]                   bht_select,
    output logic                         bht_inc,
    output logic                         btb_we,
    output logic [`BHT_INDEX_WIDTH-1:0]  btb_index,
    output bpu_types_pkg::btb_line_u     btb_wmask,
    output bpu_types_pkg::btb_line_u     btb_wdata
);

    logic is_jal, is_jalr, is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu;
    logic equal, less_than, less_than_u, br_taken, taken;
    logic [1:0] slot_sel;
    bju_types_pkg::pc_t pc_plus4, br_target, jalr_target, taken_target;

    assign is_jal  = iss_cx_type[bju_types_pkg::CX_JAL];
    assign is_jalr = iss_cx_type[bju_types_pkg::CX_JALR];
    assign is_beq  = iss_cx_type[bju_types_pkg::CX_BEQ] & ~iss_is_unsigned;
    assign is_bne  = iss_cx_type[bju_types_pkg::CX_BNE] & ~iss_is_unsigned;
    assign is_blt  = iss_cx_type[bju_types_pkg::CX_BLT] & ~iss_is_unsigned;
    assign is_bge  = iss_cx_type[bju_types_pkg::CX_BGE] & ~iss_is_unsigned;
    assign is_bltu = iss_cx_type[bju_types_pkg::CX_BLT] & iss_is_unsigned;
    assign is_bgeu = iss_cx_type[bju_types_pkg::CX_BGE] & iss_is_unsigned;

    assign equal       = (iss_src1 == iss_src2);
    assign less_than_u = (iss_src1 < iss_src2);

    // signed compare by the sign bits first, then by the lower bits
    always_comb begin
        case ({iss_src1[`BJU_SRC_WIDTH-1], iss_src2[`BJU_SRC_WIDTH-1]})
            2'b01:   less_than = 1'b0;
            2'b10:   less_than = 1'b1;
            default: less_than = iss_src1[`BJU_SRC_WIDTH-2:0] < iss_src2[`BJU_SRC_WIDTH-2:0];
        endcase
    end

    assign br_taken = (is_beq & equal) | (is_bne & ~equal)
                    | (is_blt & less_than) | (is_bge & ~less_than)
                    | (is_bltu & less_than_u) | (is_bgeu & ~less_than_u);
    assign taken    = is_jal | is_jalr | br_taken;

    assign pc_plus4     = iss_pc + `BJU_PC_WIDTH'd4;
    assign br_target    = iss_pc + iss_imm[`BJU_PC_WIDTH-1:0];
    assign jalr_target  = iss_src1[`BJU_PC_WIDTH-1:0] + iss_imm[`BJU_PC_WIDTH-1:0];
    assign taken_target = is_jalr ? jalr_target : br_target;

    assign dest = {{(`BJU_RESULT_WIDTH-`BJU_PC_WIDTH){1'b0}}, pc_plus4};

    // redirect only when outcome and prediction disagree
    assign redirect_valid  = iss_valid & (taken ^ iss_predict_taken);
    assign redirect_target = taken ? taken_target : pc_plus4;

    // every resolved branch trains its counter
    assign slot_sel   = iss_pc[3:2];
    assign bht_we     = iss_valid;
    assign bht_index  = iss_pc[`BHT_INDEX_WIDTH+3:4];
    assign bht_select = slot_sel;
    assign bht_inc    = taken;

    // btb learns a target only on a taken branch that was predicted not taken
    assign btb_we    = iss_valid & taken & ~iss_predict_taken;
    assign btb_index = iss_pc[`BHT_INDEX_WIDTH+3:4];

    always_comb begin
        btb_wdata.bits                  = '0;
        btb_wmask.bits                  = '0;
        btb_wdata.fields.valid          = 1'b1;
        btb_wmask.fields.valid          = 1'b1;
        btb_wdata.fields.slots[slot_sel] = taken_target[`BTB_SLOT_WIDTH-1:0];
        btb_wmask.fields.slots[slot_sel] = '1;  // only the addressed slot
    end

    // issue side must hand over a single branch kind
    a_cx_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        iss_valid |-> $onehot0(iss_cx_type))
        else $error("bju_resolve: more than one branch kind set");

endmodule

// File: rtl/bht_counters.sv
`timescale 1ns/1ps
`include "bju_settings.svh"

module bht_counters (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        we,
    input  logic [`BHT_INDEX_WIDTH-1:0] index,
    input  logic [1:0]                  select,
    input  logic                        inc,
    input  bju_types_pkg::pc_t          lookup_pc,
    output bpu_types_pkg::bht_ctr_t     lookup_counter
);

    localparam int SETS = 1 << `BHT_INDEX_WIDTH;

    bpu_types_pkg::bht_ctr_t ctr_q [SETS][4];
    bpu_types_pkg::bht_ctr_t cur_ctr;
    bpu_types_pkg::bht_ctr_t next_ctr;

    assign cur_ctr = ctr_q[index][select];

    // saturate at both ends
    always_comb begin
        if (inc) begin
            next_ctr = (cur_ctr == 2'd3) ? 2'd3 : cur_ctr + 2'd1;
        end else begin
            next_ctr = (cur_ctr == 2'd0) ? 2'd0 : cur_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                for (int c = 0; c < 4; c++) begin
                    ctr_q[s][c] <= bpu_types_pkg::BHT_CTR_INIT;
                end
            end
        end else if (we) begin
            ctr_q[index][select] <= next_ctr;
        end
    end

    // fetch side read, same set/slot split as the update
    assign lookup_counter = ctr_q[lookup_pc[`BHT_INDEX_WIDTH+3:4]][lookup_pc[3:2]];

    // a write moves a counter by one step at most
    a_no_jump_0_to_3: assert property (@(posedge clk) disable iff (!rst_n)
        (we && cur_ctr == 2'd0) |=> ctr_q[$past(index)][$past(select)] != 2'd3)
        else $error("bht_counters: counter went from 0 to 3 in one write");

endmodule

// File: rtl/btb_array.sv
`timescale 1ns/1ps
`include "bju_settings.svh"

module btb_array (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        we,
    input  logic [`BHT_INDEX_WIDTH-1:0] index,
    input  bpu_types_pkg::btb_line_u    wmask,
    input  bpu_types_pkg::btb_line_u    wdata,
    input  bju_types_pkg::pc_t          lookup_pc,
    output logic                        lookup_hit,
    output logic [`BTB_SLOT_WIDTH-1:0]  lookup_target
);

    localparam int LINES = 1 << `BHT_INDEX_WIDTH;

    logic [`BTB_SLOTS*`BTB_SLOT_WIDTH:0] mem [LINES];  // target storage, no reset
    logic [LINES-1:0]                    valid_q;
    logic [`BHT_INDEX_WIDTH-1:0]         rd_index;
    bpu_types_pkg::btb_line_u            rd_line;

    // bitwise merge of old line and new data
    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= (mem[index] & ~wmask.bits) | (wdata.bits & wmask.bits);
        end
    end

    // valid bits live apart so reset can clear them in one go
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (we && wmask.fields.valid) begin
            valid_q[index] <= wdata.fields.valid;
        end
    end

    assign rd_index     = lookup_pc[`BHT_INDEX_WIDTH+3:4];
    assign rd_line.bits = mem[rd_index];

    assign lookup_hit    = valid_q[rd_index];
    assign lookup_target = rd_line.fields.slots[lookup_pc[3:2]];  // slot by pc[3:2]

endmodule

// File: rtl/bju_top.sv
`timescale 1ns/1ps
`include "bju_settings.svh"

module bju_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         valid,
    input  bju_types_pkg::src_t          src1,
    input  bju_types_pkg::src_t          src2,
    input  bju_types_pkg::src_t          imm,
    input  bju_types_pkg::pc_t           pc,
    input  logic [`BJU_CX_WIDTH-1:0]     cx_type,
    input  logic                         is_unsigned,
    input  logic                         predict_taken,
    output bju_types_pkg::result_t       dest,
    output logic                         redirect_valid,
    output bju_types_pkg::pc_t           redirect_target,
    input  bju_types_pkg::pc_t           lookup_pc,
    output bpu_types_pkg::bht_ctr_t      lookup_counter,
    output logic                         lookup_hit,
    output logic [`BTB_SLOT_WIDTH-1:0]   lookup_target
);

    logic                        iss_valid, iss_is_unsigned, iss_predict_taken;
    bju_types_pkg::src_t         iss_src1, iss_src2, iss_imm;
    bju_types_pkg::pc_t          iss_pc;
    logic [`BJU_CX_WIDTH-1:0]    iss_cx_type;
    logic                        bht_we, bht_inc, btb_we;
    logic [`BHT_INDEX_WIDTH-1:0] bht_index, btb_index;
    logic [1:0]                  bht_select;
    bpu_types_pkg::btb_line_u    btb_wmask, btb_wdata;

    bju_issue_stage u_issue (
        .clk(clk), .rst_n(rst_n), .valid(valid),
        .src1(src1), .src2(src2), .imm(imm), .pc(pc),
        .cx_type(cx_type), .is_unsigned(is_unsigned), .predict_taken(predict_taken),
        .iss_valid(iss_valid), .iss_src1(iss_src1), .iss_src2(iss_src2),
        .iss_imm(iss_imm), .iss_pc(iss_pc), .iss_cx_type(iss_cx_type),
        .iss_is_unsigned(iss_is_unsigned), .iss_predict_taken(iss_predict_taken)
    );

    bju_resolve u_resolve (
        .clk(clk), .rst_n(rst_n), .iss_valid(iss_valid),
        .iss_src1(iss_src1), .iss_src2(iss_src2), .iss_imm(iss_imm), .iss_pc(iss_pc),
        .iss_cx_type(iss_cx_type), .iss_is_unsigned(iss_is_unsigned),
        .iss_predict_taken(iss_predict_taken),
        .dest(dest), .redirect_valid(redirect_valid), .redirect_target(redirect_target),
        .bht_we(bht_we), .bht_index(bht_index), .bht_select(bht_select), .bht_inc(bht_inc),
        .btb_we(btb_we), .btb_index(btb_index), .btb_wmask(btb_wmask), .btb_wdata(btb_wdata)
    );

    bht_counters u_bht (
        .clk(clk), .rst_n(rst_n), .we(bht_we), .index(bht_index),
        .select(bht_select), .inc(bht_inc),
        .lookup_pc(lookup_pc), .lookup_counter(lookup_counter)
    );

    btb_array u_btb (
        .clk(clk), .rst_n(rst_n), .we(btb_we), .index(btb_index),
        .wmask(btb_wmask), .wdata(btb_wdata),
        .lookup_pc(lookup_pc), .lookup_hit(lookup_hit), .lookup_target(lookup_target)
    );

endmodule

// File: dv/tb_bju_tests.svh
`ifndef TB_BJU_TESTS_SVH
`define TB_BJU_TESTS_SVH

task automatic report_error(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopping at first error");
endtask

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
        $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        report_error("value mismatch");
    end
endtask

task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
        @(posedge clk);  // rst_n moves on the falling edge
        cycles++;
        if (cycles > 40) begin
            report_error("reset was not released within 40 cycles");
        end
    end
    @(negedge clk);
endtask

// lookup ports are combinational and get a short settle before the compare
task automatic check_lookup(input bju_types_pkg::pc_t pcv);
    int idx;
    int sl;
    idx       = int'(pcv[12:4]);
    sl        = int'(pcv[3:2]);
    lookup_pc = pcv;
    #5;
    check_value("lookup_counter", 64'(lookup_counter), 64'(ref_ctr[idx][sl]));
    check_value("lookup_hit", 64'(lookup_hit), 64'(ref_hit[idx]));
    if (ref_hit[idx] && ref_known[idx][sl]) begin
        check_value("lookup_target", 64'(lookup_target), 64'(ref_slot[idx][sl]));
    end
endtask

// one branch with the redirect checked after edge N and the tables after edge N+1
task automatic run_branch(input logic [5:0] cx, input logic uns, input logic [63:0] a,
                          input logic [63:0] b, input logic [63:0] immv,
                          input bju_types_pkg::pc_t pcv, input logic pred);
    logic               taken;
    bju_types_pkg::pc_t tgt;
    bju_types_pkg::pc_t link;
    taken = model_taken(cx, uns, a, b);
    tgt   = model_target(cx, a, immv, pcv);
    link  = pcv + 48'd4;
    @(negedge clk);
    valid         = 1'b1;
    src1          = a;
    src2          = b;
    imm           = immv;
    pc            = pcv;
    cx_type       = cx;
    is_unsigned   = uns;
    predict_taken = pred;
    @(negedge clk);
    valid = 1'b0;
    check_value("redirect_valid", 64'(redirect_valid), 64'(taken != pred));
    if (taken != pred) begin
        check_value("redirect_target", 64'(redirect_target), 64'(taken ? tgt : link));
    end
    check_value("dest", dest, {16'h0, link});
    model_train(pcv, taken, pred, tgt[31:0]);
    @(negedge clk);
    check_lookup(pcv);
endtask

task automatic test_after_reset();
    bju_types_pkg::pc_t pcs [4];
    pcs = '{48'h0, 48'h1_0004, 48'h7ff8, 48'hffff_ffff_fffc};
    for (int i = 0; i < 4; i++) begin
        @(negedge clk);
        check_value("redirect_valid", 64'(redirect_valid), 64'd0);
        check_value("lookup_counter", 64'(lookup_counter), 64'd1);  // weak not taken
        check_lookup(pcs[i]);
    end
endtask

task automatic test_cond_branches();
    logic [63:0]        neg5;
    bju_types_pkg::pc_t base;
    neg5 = 64'hffff_ffff_ffff_fffb;
    for (int p = 0; p < 2; p++) begin
        base = (p == 0) ? 48'h2000 : 48'h2100;
        run_branch(6'b000100, 1'b0, 64'd5, 64'd5, 64'h40, base, p[0]);
        run_branch(6'b001000, 1'b0, 64'd5, 64'd5, 64'h40, base + 48'h10, p[0]);
        run_branch(6'b010000, 1'b0, neg5, 64'd3, 64'hffff_ffff_ffff_ff80, base + 48'h24, p[0]);
        run_branch(6'b100000, 1'b0, neg5, 64'd3, 64'h100, base + 48'h38, p[0]);
        run_branch(6'b010000, 1'b1, neg5, 64'd3, 64'h100, base + 48'h4c, p[0]);  // bltu
        run_branch(6'b100000, 1'b1, neg5, 64'd3, 64'h20, base + 48'h50, p[0]);   // bgeu
        run_branch(6'b010000, 1'b0, 64'd3, neg5, 64'h20, base + 48'h64, p[0]);
        run_branch(6'b100000, 1'b0, 64'd3, neg5, 64'h200, base + 48'h78, p[0]);
    end
endtask

task automatic test_jumps();
    for (int p = 0; p < 2; p++) begin
        run_branch(6'b000001, 1'b0, 64'd0, 64'd0, 64'h800, 48'h3000 + 48'(p * 16), p[0]);
        run_branch(6'b000010, 1'b0, 64'h0000_1234_5678_0000, 64'd0, 64'h10,
                   48'h3100 + 48'(p * 16), p[0]);
    end
endtask

task automatic test_bht_training();
    for (int i = 0; i < 4; i++) begin
        run_branch(6'b000100, 1'b0, 64'd1, 64'd1, 64'h40, 48'h5040, 1'b1);
    end
    check_value("lookup_counter", 64'(lookup_counter), 64'd3);
    @(negedge clk);
    check_lookup(48'h5044);  // neighbour slot
    check_value("lookup_counter", 64'(lookup_counter), 64'd1);
    for (int i = 0; i < 5; i++) begin
        run_branch(6'b001000, 1'b0, 64'd1, 64'd1, 64'h40, 48'h5040, 1'b0);
    end
    check_value("lookup_counter", 64'(lookup_counter), 64'd0);
endtask

task automatic test_btb_mask();
    @(negedge clk);
    check_lookup(48'h6fa8);
    check_value("lookup_hit", 64'(lookup_hit), 64'd0);
    run_branch(6'b000100, 1'b0, 64'd9, 64'd9, 64'h1230, 48'h6fa8, 1'b0);  // slot 2
    check_value("lookup_target", 64'(lookup_target), 64'h0000_81d8);
    run_branch(6'b001000, 1'b0, 64'd1, 64'd2, 64'h400, 48'h6fa0, 1'b0);   // slot 0
    @(negedge clk);
    check_lookup(48'h6fa8);
    check_value("lookup_target", 64'(lookup_target), 64'h0000_81d8);
endtask

task automatic test_random();
    logic [5:0]         cx;
    logic               uns;
    logic [63:0]        a;
    logic [63:0]        b;
    logic [63:0]        immv;
    bju_types_pkg::pc_t pcv;
    int                 kind;
    int                 r;
    for (int i = 0; i < 40; i++) begin
        kind = 2 + int'($unsigned($random(seed)) % 4);
        cx   = 6'(1 << kind);
        r    = $random(seed);
        uns  = (kind >= 4) ? r[1] : 1'b0;
        a    = {$random(seed), $random(seed)};
        b    = (r[3:2] == 2'd0) ? a : {$random(seed), $random(seed)};
        immv = {{52{r[15]}}, r[15:4]};
        pcv  = 48'({$random(seed), $random(seed)});
        pcv[1:0] = 2'b00;
        run_branch(cx, uns, a, b, immv, pcv, r[0]);
    end
endtask

`endif

// File: dv/tb_bju.sv
`timescale 1ns/1ps
`include "bju_settings.svh"

module tb_bju;

    logic                       clk;
    logic                       rst_n;
    logic                       valid;
    bju_types_pkg::src_t        src1;
    bju_types_pkg::src_t        src2;
    bju_types_pkg::src_t        imm;
    bju_types_pkg::pc_t         pc;
    logic [`BJU_CX_WIDTH-1:0]   cx_type;
    logic                       is_unsigned;
    logic                       predict_taken;
    bju_types_pkg::result_t     dest;
    logic                       redirect_valid;
    bju_types_pkg::pc_t         redirect_target;
    bju_types_pkg::pc_t         lookup_pc;
    bpu_types_pkg::bht_ctr_t    lookup_counter;
    logic                       lookup_hit;
    logic [`BTB_SLOT_WIDTH-1:0] lookup_target;

    // reference copy of both predictor tables
    logic [1:0]  ref_ctr   [512][4];
    logic        ref_hit   [512];
    logic [31:0] ref_slot  [512][4];
    logic        ref_known [512][4];  // slot was written since reset
    integer      seed;

    bju_top u_dut (
        .clk(clk), .rst_n(rst_n), .valid(valid), .src1(src1), .src2(src2),
        .imm(imm), .pc(pc), .cx_type(cx_type), .is_unsigned(is_unsigned),
        .predict_taken(predict_taken), .dest(dest), .redirect_valid(redirect_valid),
        .redirect_target(redirect_target), .lookup_pc(lookup_pc),
        .lookup_counter(lookup_counter), .lookup_hit(lookup_hit),
        .lookup_target(lookup_target)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

    // branch direction from plain signed and unsigned compares
    function automatic logic model_taken(input logic [5:0] cx, input logic uns,
                                         input logic [63:0] a, input logic [63:0] b);
        logic lt;
        lt = uns ? (a < b) : ($signed(a) < $signed(b));
        if (cx[0] || cx[1]) return 1'b1;  // jal, jalr
        if (cx[2]) return a == b;
        if (cx[3]) return a != b;
        if (cx[4]) return lt;
        if (cx[5]) return !lt;
        return 1'b0;
    endfunction

    function automatic bju_types_pkg::pc_t model_target(input logic [5:0] cx,
            input logic [63:0] a, input logic [63:0] immv, input bju_types_pkg::pc_t pcv);
        return cx[1] ? a[47:0] + immv[47:0] : pcv + immv[47:0];
    endfunction

    task automatic model_train(input bju_types_pkg::pc_t pcv, input logic taken,
                               input logic pred, input logic [31:0] tgt);
        int idx;
        int sl;
        idx = int'(pcv[12:4]);
        sl  = int'(pcv[3:2]);
        if (taken && ref_ctr[idx][sl] != 2'd3) begin
            ref_ctr[idx][sl] = ref_ctr[idx][sl] + 2'd1;
        end else if (!taken && ref_ctr[idx][sl] != 2'd0) begin
            ref_ctr[idx][sl] = ref_ctr[idx][sl] - 2'd1;
        end
        if (taken && !pred) begin  // learn target on a missed taken branch
            ref_hit[idx]       = 1'b1;
            ref_slot[idx][sl]  = tgt;
            ref_known[idx][sl] = 1'b1;
        end
    endtask

    `include "tb_bju_tests.svh"

    initial begin
        valid         = 1'b0;
        src1          = '0;
        src2          = '0;
        imm           = '0;
        pc            = '0;
        cx_type       = '0;
        is_unsigned   = 1'b0;
        predict_taken = 1'b0;
        lookup_pc     = '0;
        seed          = 32'h3b81;
        for (int s = 0; s < 512; s++) begin
            ref_hit[s] = 1'b0;
            for (int c = 0; c < 4; c++) begin
                ref_ctr[s][c]   = 2'b01;
                ref_slot[s][c]  = '0;
                ref_known[s][c] = 1'b0;
            end
        end
        wait_reset_release();
        test_after_reset();
        test_cond_branches();
        test_jumps();
        test_bht_training();
        test_btb_mask();
        test_random();
        $display("sim passed");
        $finish;
    end

endmodule

// File: build.f
+incdir+rtl
+incdir+dv
rtl/bju_types_pkg.sv
rtl/bpu_types_pkg.sv
rtl/bju_issue_stage.sv
rtl/bju_resolve.sv
rtl/bht_counters.sv
rtl/btb_array.sv
rtl/bju_top.sv
dv/tb_bju.sv

// File: Makefile
# Verilator build, run and lint for the branch resolution slice

VERILATOR  ?= verilator
TB_TOP     ?= tb_bju
RTL_TOP    ?= bju_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the simulation status is taken from the log, not from the exit code
run: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^sim passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
